//--- mips_debug_core.f
logic/mips_isa_pkg.sv
logic/debug_snap_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/alu_execute.sv
logic/snapshot_packer.sv
logic/mips_debug_core.sv
test/tb_mips_debug_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f mips_debug_core.f --top-module tb_mips_debug_core -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_mips_debug_core 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "pass message not found"
exit 1

//--- test/tb_mips_debug_core.sv
module tb_mips_debug_core import mips_isa_pkg::*, debug_snap_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_NS      = 40;
	localparam int N_RANDOM    = 40;          // random alu instructions
	localparam int N_SNAPS     = 7;           // snapshots over the whole run
	localparam int N_CYCLES    = 3 * N_RANDOM + 40; // instructions plus idle gaps
	localparam int WATCHDOG_NS = 2 * (N_CYCLES + 160 * N_SNAPS) * CLK_NS;

	logic       clk;
	logic       arst_n;
	logic       instr_valid;
	word_t      instr;
	logic       snap_req;
	snap_byte_t snap_byte;
	logic       snap_byte_valid;
	logic       snap_busy;

	word_t       model_regs [REG_COUNT];      // reference register file
	word_t       model_pc;
	snap_frame_t last_frame;                  // most recent rebuilt frame

	mips_debug_core dut (
		.clk(clk), .arst_n(arst_n),
		.instr_valid(instr_valid), .instr(instr), .snap_req(snap_req),
		.snap_byte(snap_byte), .snap_byte_valid(snap_byte_valid), .snap_busy(snap_busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// failure reporting

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			fail_now($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	//////////////////////////////////////////////////
	// encoders and reference model

	// arguments in assembly order op rt rs imm
	function automatic word_t enc_i(input opcode_t op, input int rt, input int rs,
	                                input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic word_t enc_r(input funct_t fn, input int rd, input int rs,
	                                input int rt);
		return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	task automatic model_exec(input word_t w);
		word_t     a;
		word_t     b;
		word_t     sext;
		word_t     res;
		reg_addr_t dst;
		a    = model_regs[w[25:21]];          // rs
		b    = model_regs[w[20:16]];          // rt
		sext = {{16{w[15]}}, w[15:0]};
		res  = '0;
		dst  = '0;                            // r0 doubles as no write
		case (w[31:26])
		OP_RTYPE:
		begin
			dst = w[15:11];
			case (w[5:0])
			FN_ADDU: res = a + b;
			FN_SUBU: res = a - b;
			FN_AND:  res = a & b;
			FN_OR:   res = a | b;
			FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: dst = '0;                // unsupported funct
			endcase
		end
		OP_ADDI:
		begin
			dst = w[20:16];
			res = a + sext;
		end
		OP_ORI:
		begin
			dst = w[20:16];
			res = a | {16'h0000, w[15:0]};    // zero extended
		end
		OP_BEQ:
			if (a == b)
				model_pc = model_pc + (sext << 2); // offset counts from pc+4
		default: ;
		endcase
		if (dst != '0)
			model_regs[dst] = res;
		model_pc = model_pc + 32'd4;
	endtask

	//////////////////////////////////////////////////
	// stimulus

	task automatic send_instr(input word_t w);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= w;
		model_exec(w);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			instr_valid <= 1'b0;
		end
	endtask

	// extra_at is the byte index that triggers a second request or -1 for none
	task automatic take_snapshot(input int extra_at);
		logic [SNAP_BYTES*8-1:0] raw;
		snap_frame_t             frame;
		idle_cycles(2);                       // drain both stages
		@(posedge clk);
		snap_req <= 1'b1;
		@(posedge clk);                       // request sampled here
		snap_req <= 1'b0;
		raw = '0;
		for (int k = 0; k < SNAP_BYTES; k++)
		begin
			@(negedge clk);
			if (!snap_byte_valid)
				fail_now($sformatf("snapshot byte %0d did not arrive", k));
			check_eq("snap_busy during frame", word_t'(snap_busy), 32'd1);
			raw[k*8 +: 8] = snap_byte;        // low byte first
			@(posedge clk);
			snap_req <= (k == extra_at);
		end
		@(negedge clk);
		check_eq("snap_byte_valid after frame", word_t'(snap_byte_valid), 32'd0);
		check_eq("snap_busy after frame", word_t'(snap_busy), 32'd0);
		frame = snap_frame_t'(raw);
		check_eq("snapshot pc", frame.pc, model_pc);
		for (int i = 0; i < REG_COUNT; i++)
			check_eq($sformatf("snapshot r%0d", i), frame.regs[i], model_regs[i]);
		// bubble in stage leaves instr, control and hazard bytes at zero
		for (int k = 4; k < SNAP_BYTES; k++)
			if (k < 13 || k > 140)
				check_eq($sformatf("snapshot byte %0d", k), word_t'(raw[k*8 +: 8]), 32'd0);
		last_frame = frame;
	endtask

	//////////////////////////////////////////////////
	// directed tests

	task automatic snapshot_after_reset();
		@(negedge clk);
		check_eq("snap_busy after reset", word_t'(snap_busy), 32'd0);
		check_eq("snap_byte_valid after reset", word_t'(snap_byte_valid), 32'd0);
		take_snapshot(-1);                    // model still all zero
	endtask

	task automatic random_alu_sequence();
		int kind;
		int rs;
		int rt;
		int rd;
		int imm;
		send_instr(enc_i(OP_ADDI, 1, 0, 16'h8001)); // negative value for slt
		send_instr(enc_i(OP_ADDI, 2, 0, 16'h0005));
		send_instr(enc_r(FN_SLT, 3, 1, 2));
		send_instr(enc_r(FN_SLT, 4, 2, 1));
		for (int i = 0; i < N_RANDOM; i++)
		begin
			kind = $urandom % 7;
			rs   = $urandom % 8;              // small set for many dependencies
			rt   = $urandom % 8;
			rd   = $urandom % 8;
			imm  = $urandom;
			case (kind)
			0: send_instr(enc_i(OP_ADDI, rt, rs, imm[15:0]));
			1: send_instr(enc_i(OP_ORI, rt, rs, imm[15:0]));
			2: send_instr(enc_r(FN_ADDU, rd, rs, rt));
			3: send_instr(enc_r(FN_SUBU, rd, rs, rt));
			4: send_instr(enc_r(FN_AND, rd, rs, rt));
			5: send_instr(enc_r(FN_OR, rd, rs, rt));
			default: send_instr(enc_r(FN_SLT, rd, rs, rt));
			endcase
			if ($urandom % 4 == 0)
				idle_cycles(1 + $urandom % 2);
		end
		take_snapshot(-1);
	endtask

	task automatic forwarding_chain();
		send_instr(enc_i(OP_ADDI, 3, 0, 16'h0011));
		send_instr(enc_r(FN_ADDU, 4, 3, 3));  // both operands forwarded
		send_instr(enc_r(FN_SUBU, 5, 4, 0));
		send_instr(enc_r(FN_OR, 6, 2, 5));    // rt forwarded
		send_instr(enc_r(FN_SLT, 7, 6, 1));
		send_instr(enc_i(OP_ORI, 8, 7, 16'hf0f0));
		send_instr(enc_r(FN_AND, 9, 8, 8));
		take_snapshot(-1);
	endtask

	task automatic branch_targets();
		word_t pc_start;
		pc_start = model_pc;
		send_instr(enc_i(OP_ADDI, 10, 0, 16'h0042));
		send_instr(enc_i(OP_ADDI, 11, 0, 16'h0042));
		send_instr(enc_i(OP_ADDI, 12, 0, 16'h0007));
		idle_cycles(1);
		send_instr(enc_i(OP_BEQ, 11, 10, 16'h0003)); // equal so pc moves by 16
		send_instr(enc_i(OP_BEQ, 12, 10, 16'h0005)); // not equal so pc moves by 4
		send_instr(enc_i(OP_BEQ, 10, 10, 16'hfff8)); // back by 28
		take_snapshot(-1);
		check_eq("pc after branches", last_frame.pc, pc_start + 32'd4);
	endtask

	task automatic dropped_writes();
		word_t pc_start;
		pc_start = model_pc;
		send_instr(enc_i(OP_ADDI, 0, 1, 16'h1234));  // r0 destination
		send_instr(enc_r(FN_ADDU, 0, 1, 2));
		send_instr(enc_r(6'h00, 5, 1, 2));            // sll funct is unsupported
		send_instr(enc_i(6'h23, 6, 1, 16'h0010));     // lw opcode without data memory
		send_instr(enc_i(6'h3f, 7, 7, 16'hffff));
		take_snapshot(-1);
		check_eq("pc after five nops", last_frame.pc, pc_start + 32'd20);
	endtask

	task automatic second_request_ignored();
		send_instr(enc_i(OP_ORI, 13, 0, 16'h5a5a));
		take_snapshot(50);                    // second pulse mid transfer
		take_snapshot(-1);
	endtask

	//////////////////////////////////////////////////
	// sequence and watchdog

	initial
	begin
		void'($urandom(81));
		arst_n      <= 1'b0;
		instr_valid <= 1'b0;
		instr       <= '0;
		snap_req    <= 1'b0;
		model_pc     = '0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		snapshot_after_reset();
		random_alu_sequence();
		forwarding_chain();
		branch_targets();
		dropped_writes();
		second_request_ignored();
		$display("NO ERRORS");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		fail_now("timeout: the test sequence did not finish in time");
	end

endmodule

//--- logic/mips_debug_core.sv
module mips_debug_core import mips_isa_pkg::*, debug_snap_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       instr_valid,        // instr strobe
	input  word_t      instr,
	input  logic       snap_req,           // one-cycle pulse
	output snap_byte_t snap_byte,
	output logic       snap_byte_valid,
	output logic       snap_busy
);

	//////////////////////////////////////////////////
	// internal nets
	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t     rd_data_a;
	word_t     rd_data_b;
	ex_stage_t dec_out;                    // decode to execute
	fwd_sel_e  dec_fwd_a;
	fwd_sel_e  dec_fwd_b;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      ex_writes;                  // forward path
	reg_addr_t ex_dest;
	word_t     ex_result;
	word_t     pc;
	word_t     ex_instr;
	ctrl_t     ex_ctrl;
	fwd_sel_e  ex_fwd_a;
	fwd_sel_e  ex_fwd_b;
	reg_dump_t reg_dump;                   // rf to snapshot

	instr_decoder u_decode (
		.instr_valid(instr_valid), .instr(instr),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.ex_writes(ex_writes), .ex_dest(ex_dest), .ex_result(ex_result),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.dec_out(dec_out), .dec_fwd_a(dec_fwd_a), .dec_fwd_b(dec_fwd_b)
	);

	reg_file u_regs (
		.clk(clk), .arst_n(arst_n),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
		.reg_dump(reg_dump)
	);

	alu_execute u_execute (
		.clk(clk), .arst_n(arst_n),
		.instr_valid(instr_valid), .dec_out(dec_out),
		.dec_fwd_a(dec_fwd_a), .dec_fwd_b(dec_fwd_b),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
		.ex_writes(ex_writes), .ex_dest(ex_dest), .ex_result(ex_result),
		.pc(pc), .ex_instr(ex_instr), .ex_ctrl(ex_ctrl),
		.ex_fwd_a(ex_fwd_a), .ex_fwd_b(ex_fwd_b)
	);

	snapshot_packer u_result (
		.clk(clk), .arst_n(arst_n), .snap_req(snap_req),
		.pc(pc), .ex_instr(ex_instr), .ex_ctrl(ex_ctrl),
		.ex_fwd_a(ex_fwd_a), .ex_fwd_b(ex_fwd_b), .reg_dump(reg_dump),
		.snap_byte(snap_byte), .snap_byte_valid(snap_byte_valid),
		.snap_busy(snap_busy)
	);

endmodule

//--- logic/snapshot_packer.sv
module snapshot_packer import mips_isa_pkg::*, debug_snap_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       snap_req,           // one-cycle pulse
	input  word_t      pc,
	input  word_t      ex_instr,
	input  ctrl_t      ex_ctrl,
	input  fwd_sel_e   ex_fwd_a,
	input  fwd_sel_e   ex_fwd_b,
	input  reg_dump_t  reg_dump,
	output snap_byte_t snap_byte,
	output logic       snap_byte_valid,    // one pulse per byte
	output logic       snap_busy
);

	snap_frame_t frame_d;                  // live view of the core
	snap_frame_t frame_q;                  // latched frame that shifts down
	snap_state_e state_q;
	snap_cnt_t   cnt_q;                    // index of the byte on the port
	logic        accept;
	logic        last_byte;

	//////////////////////////////////////////////////
	// frame assembly with narrow fields padded to a byte
	always_comb
	begin
		frame_d.pc           = pc;
		frame_d.instr        = ex_instr;
		frame_d.reg_write    = {7'b0, ex_ctrl.reg_write};
		frame_d.alu_op       = {5'b0, ex_ctrl.alu_op};
		frame_d.alu_src_imm  = {7'b0, ex_ctrl.alu_src_imm};
		frame_d.imm_zero_ext = {7'b0, ex_ctrl.imm_zero_ext};
		frame_d.branch       = {7'b0, ex_ctrl.branch};
		frame_d.regs         = reg_dump;
		frame_d.fwd_a        = {7'b0, ex_fwd_a};
		frame_d.fwd_b        = {7'b0, ex_fwd_b};
	end

	assign accept    = snap_req && (state_q == SNAP_IDLE); // busy drops requests
	assign last_byte = (cnt_q == snap_cnt_t'(SNAP_BYTES - 1));

	//////////////////////////////////////////////////
	// serializer fsm
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q         <= SNAP_IDLE;
			cnt_q           <= '0;
			snap_byte_valid <= 1'b0;
		end
		else
		begin
			case (state_q)
			SNAP_IDLE:
			begin
				if (accept)
				begin
					state_q         <= SNAP_SEND;
					cnt_q           <= '0;   // byte 0 shows next cycle
					snap_byte_valid <= 1'b1;
				end
			end
			SNAP_SEND:
			begin
				if (last_byte)
				begin
					state_q         <= SNAP_IDLE;
					snap_byte_valid <= 1'b0;
				end
				else
					cnt_q <= cnt_q + 1'b1;
			end
			default: state_q <= SNAP_IDLE;
			endcase
		end
	end

	// payload shift register sends the low byte first
	always_ff @(posedge clk)
	begin
		if (accept)
			frame_q <= frame_d;
		else if (state_q == SNAP_SEND)
			frame_q <= snap_frame_t'(frame_q >> 8);
	end

	assign snap_byte = frame_q[7:0];
	assign snap_busy = (state_q == SNAP_SEND);

	a_byte_known: assert property (
		@(posedge clk) disable iff (!arst_n) snap_byte_valid |-> !$isunknown(snap_byte)
	) else $error("snapshot byte is unknown");

endmodule

//--- logic/alu_execute.sv
module alu_execute import mips_isa_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      instr_valid,
	input  ex_stage_t dec_out,
	input  fwd_sel_e  dec_fwd_a,
	input  fwd_sel_e  dec_fwd_b,
	output logic      wb_en,               // rf write request
	output reg_addr_t wb_addr,
	output word_t     wb_data,
	output logic      ex_writes,           // back to decoder
	output reg_addr_t ex_dest,
	output word_t     ex_result,
	output word_t     pc,
	output word_t     ex_instr,
	output ctrl_t     ex_ctrl,
	output fwd_sel_e  ex_fwd_a,
	output fwd_sel_e  ex_fwd_b
);

	ex_stage_t ex_q;                       // stage register
	word_t     alu_b;
	word_t     alu_y;
	word_t     pc_plus4;
	logic      taken;

	//////////////////////////////////////////////////
	// stage register
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ex_q     <= '0;                // bubble
			ex_fwd_a <= FWD_REG;
			ex_fwd_b <= FWD_REG;
		end
		else if (instr_valid)
		begin
			ex_q     <= dec_out;
			ex_fwd_a <= dec_fwd_a;         // kept for the snapshot
			ex_fwd_b <= dec_fwd_b;
		end
		else
		begin
			ex_q     <= '0;                // idle cycle loads a bubble
			ex_fwd_a <= FWD_REG;
			ex_fwd_b <= FWD_REG;
		end
	end

	//////////////////////////////////////////////////
	// alu
	assign alu_b = ex_q.ctrl.alu_src_imm ? ex_q.imm : ex_q.op_b;

	always_comb
	begin
		case (ex_q.ctrl.alu_op)
		ALU_ADD: alu_y = ex_q.op_a + alu_b;
		ALU_SUB: alu_y = ex_q.op_a - alu_b;
		ALU_AND: alu_y = ex_q.op_a & alu_b;
		ALU_OR:  alu_y = ex_q.op_a | alu_b;
		ALU_SLT: alu_y = {31'b0, $signed(ex_q.op_a) < $signed(alu_b)};
		default: alu_y = '0;
		endcase
	end

	// beq subtracts and equal operands give zero
	assign taken    = ex_q.valid && ex_q.ctrl.branch && (alu_y == '0);
	assign pc_plus4 = pc + PC_STEP;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pc <= '0;
		else if (ex_q.valid)               // bubbles hold the pc
			pc <= taken ? pc_plus4 + {ex_q.imm[29:0], 2'b00} : pc_plus4;
	end

	// writeback and forward path
	assign wb_en     = ex_q.valid && ex_q.ctrl.reg_write;
	assign wb_addr   = ex_q.dest;
	assign wb_data   = alu_y;
	assign ex_writes = wb_en;
	assign ex_dest   = ex_q.dest;
	assign ex_result = alu_y;
	assign ex_instr  = ex_q.instr;
	assign ex_ctrl   = ex_q.ctrl;

	a_alu_op_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		ex_q.ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT}
	) else $error("undefined alu_op in stage register");

endmodule

//--- logic/reg_file.sv
module reg_file import mips_isa_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  reg_addr_t rd_addr_a,
	input  reg_addr_t rd_addr_b,
	output word_t     rd_data_a,
	output word_t     rd_data_b,
	input  logic      wb_en,               // write at next edge
	input  reg_addr_t wb_addr,
	input  word_t     wb_data,
	output reg_dump_t reg_dump             // all 32 words for the snapshot
);

	reg_dump_t regs_q;                     // r0 in word 0
	logic      wr_ok;

	// r0 writes are dropped here
	assign wr_ok = wb_en && (wb_addr != REG_ZERO);

	//////////////////////////////////////////////////
	// storage
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			regs_q <= '0;                  // all registers read 0 after reset
		end
		else if (wr_ok)
		begin
			regs_q[wb_addr] <= wb_data;
		end
	end

	// combinational reads without write bypass
	assign rd_data_a = regs_q[rd_addr_a];
	assign rd_data_b = regs_q[rd_addr_b];
	assign reg_dump  = regs_q;

	// a write request carries a known address and value
	a_wb_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		wb_en |-> !$isunknown({wb_addr, wb_data})
	) else $error("register write with unknown address or data");

endmodule

//--- logic/instr_decoder.sv
module instr_decoder import mips_isa_pkg::*; (
	input  logic      instr_valid,         // instr presented this cycle
	input  word_t     instr,
	input  word_t     rd_data_a,           // rf port a for rs
	input  word_t     rd_data_b,           // rf port b for rt
	input  logic      ex_writes,           // executing instr writes back
	input  reg_addr_t ex_dest,
	input  word_t     ex_result,
	output reg_addr_t rd_addr_a,
	output reg_addr_t rd_addr_b,
	output ex_stage_t dec_out,
	output fwd_sel_e  dec_fwd_a,
	output fwd_sel_e  dec_fwd_b
);

	opcode_t   opcode;
	funct_t    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	ctrl_t     ctrl;
	reg_addr_t dest;
	logic      ex_fwd_ok;                  // ex result usable for forwarding

	// instruction fields
	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign funct  = instr[5:0];

	assign rd_addr_a = rs;
	assign rd_addr_b = rt;

	//////////////////////////////////////////////////
	// control decode
	always_comb
	begin
		ctrl        = '0;                  // unknown encodings become a nop
		ctrl.alu_op = ALU_ADD;
		dest        = REG_ZERO;
		case (opcode)
		OP_RTYPE:
		begin
			dest           = rd;
			ctrl.reg_write = 1'b1;
			case (funct)
			FN_ADDU: ctrl.alu_op = ALU_ADD;
			FN_SUBU: ctrl.alu_op = ALU_SUB;
			FN_AND:  ctrl.alu_op = ALU_AND;
			FN_OR:   ctrl.alu_op = ALU_OR;
			FN_SLT:  ctrl.alu_op = ALU_SLT;
			default: ctrl.reg_write = 1'b0; // unsupported funct
			endcase
		end
		OP_ADDI:
		begin
			dest             = rt;
			ctrl.reg_write   = 1'b1;
			ctrl.alu_src_imm = 1'b1;
		end
		OP_ORI:
		begin
			dest              = rt;
			ctrl.reg_write    = 1'b1;
			ctrl.alu_src_imm  = 1'b1;
			ctrl.imm_zero_ext = 1'b1;
			ctrl.alu_op       = ALU_OR;
		end
		OP_BEQ:
		begin
			ctrl.branch = 1'b1;            // no dest
			ctrl.alu_op = ALU_SUB;         // zero result means equal
		end
		default: ;
		endcase
	end

	// forward from the stage register but never r0
	assign ex_fwd_ok = ex_writes && (ex_dest != REG_ZERO);
	assign dec_fwd_a = (ex_fwd_ok && ex_dest == rs) ? FWD_EX : FWD_REG;
	assign dec_fwd_b = (ex_fwd_ok && ex_dest == rt) ? FWD_EX : FWD_REG;

	always_comb
	begin
		dec_out.valid = instr_valid;
		dec_out.instr = instr;
		dec_out.ctrl  = ctrl;
		dec_out.op_a  = (dec_fwd_a == FWD_EX) ? ex_result : rd_data_a;
		dec_out.op_b  = (dec_fwd_b == FWD_EX) ? ex_result : rd_data_b;
		dec_out.imm   = ctrl.imm_zero_ext ? {16'b0, instr[15:0]}
		                                  : {{16{instr[15]}}, instr[15:0]};
		dec_out.dest  = dest;
	end

endmodule

//--- logic/debug_snap_pkg.sv
package debug_snap_pkg;

	import mips_isa_pkg::*;

	//////////////////////////////////////////////////
	// serializer types

	typedef logic [7:0] snap_byte_t;       // one byte on the port
	typedef logic [7:0] snap_cnt_t;        // byte index in a frame

	localparam int SNAP_BYTES = 143;       // 4+4+5+128+2

	typedef enum logic {
		SNAP_IDLE = 1'b0,
		SNAP_SEND = 1'b1
	} snap_state_e;

	//////////////////////////////////////////////////
	// frame layout
	// first member is the top byte, pc lands in bytes 0..3
	typedef struct packed {
		snap_byte_t fwd_b;                 // byte 142
		snap_byte_t fwd_a;                 // byte 141
		reg_dump_t  regs;                  // bytes 13..140
		snap_byte_t branch;                // byte 12
		snap_byte_t imm_zero_ext;          // byte 11
		snap_byte_t alu_src_imm;           // byte 10
		snap_byte_t alu_op;                // byte 9
		snap_byte_t reg_write;             // byte 8
		word_t      instr;                 // bytes 4..7
		word_t      pc;                    // bytes 0..3
	} snap_frame_t;

endpackage

//--- logic/mips_isa_pkg.sv
package mips_isa_pkg;

	//////////////////////////////////////////////////
	// word and field types

	typedef logic [31:0] word_t;           // data or instruction word
	typedef logic [4:0]  reg_addr_t;       // register index
	typedef logic [5:0]  opcode_t;         // instr[31:26]
	typedef logic [5:0]  funct_t;          // instr[5:0] of r-type

	localparam int        REG_COUNT = 32;    // architectural registers
	localparam reg_addr_t REG_ZERO  = 5'd0;  // hardwired zero
	localparam word_t     PC_STEP   = 32'd4; // one word per instruction

	//////////////////////////////////////////////////
	// instruction encodings

	localparam opcode_t OP_RTYPE = 6'h00;  // special, see funct
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_ADDI  = 6'h08;  // no overflow trap here
	localparam opcode_t OP_ORI   = 6'h0d;

	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_SLT  = 6'h2a;    // signed compare

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,                    // also beq compare
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	typedef enum logic {
		FWD_REG = 1'b0,                    // operand from register file
		FWD_EX  = 1'b1                     // operand from execute result
	} fwd_sel_e;

	//////////////////////////////////////////////////
	// decoded bundles

	typedef struct packed {
		logic    reg_write;                // result goes to dest
		alu_op_e alu_op;
		logic    alu_src_imm;              // operand b is imm
		logic    imm_zero_ext;             // ori style extension
		logic    branch;                   // beq
	} ctrl_t;

	typedef struct packed {
		logic      valid;                  // 0 means bubble
		word_t     instr;
		ctrl_t     ctrl;
		word_t     op_a;                   // rs after forwarding
		word_t     op_b;                   // rt after forwarding
		word_t     imm;                    // already extended
		reg_addr_t dest;
	} ex_stage_t;

	typedef word_t [REG_COUNT-1:0] reg_dump_t; // r0 in the low word

endpackage
